// ==== hdl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // #########################################################################
    // Widths
    // #########################################################################

    typedef logic [31:0] xlen_t;     // Data word or program counter.
    typedef logic [3:0]  reg_idx_t;  // RV32E has sixteen registers.
    typedef logic [11:0] csr_addr_t;

    // #########################################################################
    // Operation encodings
    // #########################################################################

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b  // Operand b straight through, for lui.
    } alu_op_t;

    typedef enum logic [2:0] {
        br_never,
        br_always,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_cond_t;

    typedef enum logic [1:0] {
        csr_none,
        csr_rw,
        csr_rs
    } csr_op_t;

    // Only these three CSRs are writable.
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;

endpackage

`default_nettype wire

// ==== hdl/exu_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
    input  exu_pkg::alu_op_t  alu_op,
    input  exu_pkg::br_cond_t br_cond,
    input  exu_pkg::xlen_t    a,
    input  exu_pkg::xlen_t    b,
    input  exu_pkg::xlen_t    cmp_a,
    input  exu_pkg::xlen_t    cmp_b,
    output exu_pkg::xlen_t    result,
    output logic              taken
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;

    assign shamt = b[4:0];  // Only the low five bits count for RV32.

    // The branch compare always sees the register operands, never pc or imm.
    assign cmp_eq  = (cmp_a == cmp_b);
    assign cmp_lt  = ($signed(cmp_a) < $signed(cmp_b));
    assign cmp_ltu = (cmp_a < cmp_b);

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = xlen_t'($signed(a) >>> shamt);
            alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   result = {31'b0, a < b};
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (br_cond)
            br_never:  taken = 1'b0;
            br_always: taken = 1'b1;  // Jumps take this one.
            br_eq:     taken = cmp_eq;
            br_ne:     taken = !cmp_eq;
            br_lt:     taken = cmp_lt;
            br_ge:     taken = !cmp_lt;
            br_ltu:    taken = cmp_ltu;
            br_geu:    taken = !cmp_ltu;
            default:   taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exu_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_bypass #(
    parameter int bypass_depth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  exu_pkg::reg_idx_t   rs1,
    input  exu_pkg::reg_idx_t   rs2,
    input  exu_pkg::xlen_t      rs1_data,
    input  exu_pkg::xlen_t      rs2_data,
    input  logic                push,
    input  exu_pkg::reg_idx_t   push_rd,
    input  exu_pkg::xlen_t      push_data,
    input  logic                push_is_load,
    input  logic                load_done,
    input  exu_pkg::xlen_t      load_data,
    output exu_pkg::xlen_t      src1,
    output exu_pkg::xlen_t      src2,
    output logic                wait_load
);
    import exu_pkg::*;

    // Entry 0 is the youngest write.
    reg_idx_t hist_rd     [bypass_depth];
    xlen_t    hist_data   [bypass_depth];
    logic     hist_load   [bypass_depth];
    xlen_t    filled_data [bypass_depth];
    logic     wait1;
    logic     wait2;

    // A returning load fills every entry that still waits for it.
    always_comb begin
        for (int i = 0; i < bypass_depth; i++) begin
            filled_data[i] = (load_done && hist_load[i]) ? load_data : hist_data[i];
        end
    end

    // Walk from oldest to youngest so the youngest match wins.
    always_comb begin
        src1  = rs1_data;
        src2  = rs2_data;
        wait1 = 1'b0;
        wait2 = 1'b0;
        for (int i = bypass_depth - 1; i >= 0; i--) begin
            if (rs1 != '0 && hist_rd[i] == rs1) begin
                src1  = hist_data[i];
                wait1 = hist_load[i];
            end
            if (rs2 != '0 && hist_rd[i] == rs2) begin
                src2  = hist_data[i];
                wait2 = hist_load[i];
            end
        end
    end

    assign wait_load = wait1 | wait2;

    // #########################################################################
    // History update
    // #########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bypass_depth; i++) begin
                hist_rd[i]   <= '0;
                hist_load[i] <= 1'b0;
            end
        end else if (push) begin
            hist_rd[0]   <= push_rd;
            hist_load[0] <= push_is_load;
            for (int i = 1; i < bypass_depth; i++) begin
                hist_rd[i]   <= hist_rd[i - 1];
                hist_load[i] <= hist_load[i - 1] & !load_done;
            end
        end else if (load_done) begin
            for (int i = 0; i < bypass_depth; i++) begin
                hist_load[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            hist_data[0] <= push_data;
            for (int i = 1; i < bypass_depth; i++) begin
                hist_data[i] <= filled_data[i - 1];
            end
        end else begin
            for (int i = 0; i < bypass_depth; i++) begin
                hist_data[i] <= filled_data[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exu_redirect.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_redirect (
    input  logic            clk,
    input  logic            rst,
    input  logic            accept,
    input  logic            target_valid,
    input  exu_pkg::xlen_t  target,
    input  exu_pkg::xlen_t  seq_pc,
    input  logic            pc_update,
    output logic            redirect_valid,
    output exu_pkg::xlen_t  redirect_pc
);

    logic capture;

    // A jump to the next sequential pc needs no redirect.
    // While one is pending the instruction is squashed and cannot redirect.
    assign capture = accept && target_valid && (target != seq_pc) && !redirect_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (redirect_valid) begin
            if (pc_update) begin
                redirect_valid <= 1'b0;  // Fetch has taken the new pc.
            end
        end else if (capture) begin
            redirect_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exu_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_stage #(
    parameter int bypass_depth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  exu_pkg::xlen_t      pc,
    input  exu_pkg::xlen_t      imm,
    input  exu_pkg::reg_idx_t   rd,
    input  exu_pkg::reg_idx_t   rs1,
    input  exu_pkg::reg_idx_t   rs2,
    input  exu_pkg::xlen_t      rs1_data,
    input  exu_pkg::xlen_t      rs2_data,
    input  logic                gpr_we,
    input  logic                is_load,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  exu_pkg::alu_op_t    alu_op,
    input  exu_pkg::br_cond_t   br_cond,
    input  logic                is_jump,
    input  logic                ecall,
    input  logic                mret,
    input  exu_pkg::csr_op_t    csr_op,
    input  exu_pkg::xlen_t      csr_data,
    input  logic                out_ready,
    output logic                out_valid,
    output exu_pkg::xlen_t      out_pc,
    output exu_pkg::reg_idx_t   out_rd,
    output logic                out_gpr_we,
    output logic                out_is_load,
    output exu_pkg::xlen_t      out_result,
    output exu_pkg::xlen_t      out_store_data,
    output exu_pkg::xlen_t      out_csr_wdata,
    output logic                out_mstatus_we,
    output logic                out_mtvec_we,
    output logic                out_mepc_we,
    input  logic                load_done,
    input  exu_pkg::xlen_t      load_data,
    input  logic                pc_update,
    output logic                redirect_valid,
    output exu_pkg::xlen_t      redirect_pc
);
    import exu_pkg::*;

    xlen_t     src1, src2, alu_a, alu_b, alu_result, seq_pc;
    xlen_t     wb_value, csr_wdata, next_pc;
    csr_addr_t csr_addr;
    logic      taken, wait_load, accept, push, is_csr, link, target_valid;

    assign in_ready = out_ready & !wait_load;
    assign accept   = in_valid & in_ready;
    assign push     = accept & !redirect_valid & gpr_we;  // Squashed writes never enter.

    assign alu_a  = src1_is_pc ? pc : src1;
    assign alu_b  = src2_is_imm ? imm : src2;
    assign seq_pc = pc + 32'd4;

    assign is_csr   = (csr_op != csr_none);
    assign link     = is_jump | taken;
    assign wb_value = is_csr ? csr_data : (link ? seq_pc : alu_result);

    assign csr_addr  = imm[11:0];
    assign csr_wdata = (csr_op == csr_rw) ? src1 :
                       (csr_op == csr_rs) ? (src1 | csr_data) : '0;

    // Traps take their target from the CSR file, branches from the ALU.
    assign target_valid = ecall | mret | link;
    assign next_pc      = (ecall | mret) ? csr_data : alu_result;

    exu_bypass #(
        .bypass_depth (bypass_depth)
    ) exu_bypass_inst (
        .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data, .push,
        .push_rd      (rd),
        .push_data    (wb_value),
        .push_is_load (is_load),
        .load_done, .load_data, .src1, .src2, .wait_load
    );

    exu_alu exu_alu_inst (
        .alu_op, .br_cond,
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (src1),
        .cmp_b  (src2),
        .result (alu_result),
        .taken
    );

    exu_redirect exu_redirect_inst (
        .clk, .rst, .accept, .target_valid,
        .target (next_pc),
        .seq_pc, .pc_update, .redirect_valid, .redirect_pc
    );

    // #########################################################################
    // Output register
    // #########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            out_gpr_we     <= 1'b0;
            out_is_load    <= 1'b0;
            out_mstatus_we <= 1'b0;
            out_mtvec_we   <= 1'b0;
            out_mepc_we    <= 1'b0;
        end else if (out_ready) begin
            out_valid <= accept & !redirect_valid;
            if (accept) begin
                out_gpr_we     <= gpr_we;
                out_is_load    <= is_load;
                out_mstatus_we <= is_csr && (csr_addr == csr_mstatus);
                out_mtvec_we   <= is_csr && (csr_addr == csr_mtvec);
                out_mepc_we    <= is_csr && (csr_addr == csr_mepc);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc         <= pc;
            out_rd         <= rd;
            out_result     <= wb_value;
            out_store_data <= src2;
            out_csr_wdata  <= csr_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_exu_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exu_asserts (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            in_ready,
    input wire logic            out_ready,
    input wire logic            out_valid,
    input wire logic            pc_update,
    input wire logic            redirect_valid,
    input wire exu_pkg::xlen_t  redirect_pc
);

    // Reset clears the output register and it stays clear one edge later.
    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during or right after reset");

    stall_blocks_input: assert property (@(posedge clk) disable iff (rst)
        !out_ready |-> !in_ready)
        else $error("in_ready high while out_ready is low");

    redirect_pc_stable: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !pc_update |=> $stable(redirect_pc))
        else $error("redirect_pc changed while a redirect was pending");

endmodule

bind exu_stage tb_exu_asserts tb_exu_asserts_inst (.*);

`default_nettype wire

// ==== verif/tb_exu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exu;
    import exu_pkg::*;

    // One table row: instruction fields, side actions and expected results.
    // ctl is {gpr_we, is_load, src1_is_pc, src2_is_imm, is_jump, ecall, mret}.
    // ext is {load_wait, hold, pc_upd}; we is {mstatus, mtvec, mepc}.
    typedef struct packed {
        xlen_t      pc;
        xlen_t      imm;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      d1;
        xlen_t      d2;
        logic [6:0] ctl;
        alu_op_t    op;
        br_cond_t   br;
        csr_op_t    cop;
        xlen_t      cdata;
        logic [2:0] ext;
        logic       exp_valid;
        xlen_t      exp_result;
        xlen_t      exp_csr;
        logic [2:0] exp_we;
        logic       exp_redir;
        xlen_t      exp_rpc;
        xlen_t      exp_store;
    } row_t;

    logic clk, rst, in_valid, in_ready, out_ready, out_valid;
    xlen_t pc, imm, rs1_data, rs2_data, csr_data, load_data, redirect_pc;
    reg_idx_t rd, rs1, rs2, out_rd;
    logic gpr_we, is_load, src1_is_pc, src2_is_imm, is_jump, ecall, mret;
    alu_op_t alu_op;
    br_cond_t br_cond;
    csr_op_t csr_op;
    xlen_t out_pc, out_result, out_store_data, out_csr_wdata;
    logic out_gpr_we, out_is_load, out_mstatus_we, out_mtvec_we, out_mepc_we;
    logic load_done, pc_update, redirect_valid;

    row_t    tbl [32];
    int      n_rows = 0;
    int      errors = 0;
    integer  seed = 32'hbdac;
    xlen_t   ra, rb;
    alu_op_t rand_ops [4];

    exu_stage #(.bypass_depth(4)) exu_stage_inst (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b);
        case (op)
            alu_xor:  return a ^ b;
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return a + b;
        endcase
    endfunction

    task automatic add_row(input row_t r);
        tbl[n_rows] = r;
        n_rows++;
    endtask

    task automatic run_row(input row_t r);
        pc = r.pc;
        imm = r.imm;
        rd = r.rd;
        rs1 = r.rs1;
        rs2 = r.rs2;
        rs1_data = r.d1;
        rs2_data = r.d2;
        {gpr_we, is_load, src1_is_pc, src2_is_imm, is_jump, ecall, mret} = r.ctl;
        alu_op = r.op;
        br_cond = r.br;
        csr_op = r.cop;
        csr_data = r.cdata;
        in_valid = 1'b1;
        if (r.ext[2]) begin  // Dependent on a load that has not returned yet.
            @(negedge clk);
            check_value("in_ready", in_ready, 0);
            @(posedge clk);
            #2 load_done = 1'b1;
            load_data = 32'hcafe0000;
            @(posedge clk);
            #2 load_done = 1'b0;
        end
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #2 in_valid = 1'b0;
        check_value("out_valid", out_valid, r.exp_valid);
        if (r.exp_valid) begin
            check_value("out_result", out_result, r.exp_result);
            check_value("out_csr_wdata", out_csr_wdata, r.exp_csr);
            check_value("csr_we", {out_mstatus_we, out_mtvec_we, out_mepc_we}, r.exp_we);
            check_value("out_pc", out_pc, r.pc);
            check_value("out_rd", out_rd, r.rd);
            check_value("out_gpr_we", out_gpr_we, r.ctl[6]);
            check_value("out_is_load", out_is_load, r.ctl[5]);
            check_value("out_store_data", out_store_data, r.exp_store);
        end
        check_value("redirect_valid", redirect_valid, r.exp_redir);
        if (r.exp_redir) check_value("redirect_pc", redirect_pc, r.exp_rpc);
        if (r.ext[1]) begin
            out_ready = 1'b0;
            repeat (3) begin
                @(posedge clk);
                #2 check_value("in_ready", in_ready, 0);
                check_value("out_valid", out_valid, 1);
                check_value("out_result", out_result, r.exp_result);
            end
            out_ready = 1'b1;
        end
        if (r.ext[0]) begin
            pc_update = 1'b1;
            @(posedge clk);
            #2 pc_update = 1'b0;
            check_value("redirect_valid", redirect_valid, 0);
        end
    endtask

    // ########################################################################
    // Stimulus table
    // ########################################################################

    initial begin
        {clk, in_valid, gpr_we, is_load, src1_is_pc, src2_is_imm} = '0;
        {is_jump, ecall, mret, load_done, pc_update} = '0;
        {pc, imm, rd, rs1, rs2, rs1_data, rs2_data, csr_data, load_data} = '0;
        alu_op = alu_add;
        br_cond = br_never;
        csr_op = csr_none;
        out_ready = 1'b1;
        rst = 1'b1;
        rand_ops = '{alu_xor, alu_sra, alu_slt, alu_sltu};

        add_row('{32'h0, 32'h0, 4'd1, 4'd2, 4'd3, 32'h5, 32'h7, 7'b1000000, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'hc, 32'h0, 3'b000, 1'b0, 32'h0, 32'h7});
        add_row('{32'h0, 32'h3, 4'd2, 4'd1, 4'd0, 32'h0, 32'h0, 7'b1001000, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'hf, 32'h0, 3'b000, 1'b0, 32'h0, 32'h0});
        add_row('{32'h0, 32'h0, 4'd3, 4'd2, 4'd1, 32'h0, 32'h0, 7'b1000000, alu_sub, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h3, 32'h0, 3'b000, 1'b0, 32'h0, 32'hc});
        add_row('{32'h0, 32'h12345000, 4'd0, 4'd0, 4'd0, 32'h0, 32'h0, 7'b1001000, alu_pass_b,
                  br_never, csr_none, 32'h0, 3'b000, 1'b1, 32'h12345000, 32'h0, 3'b000, 1'b0,
                  32'h0, 32'h0});
        add_row('{32'h0, 32'h0, 4'd4, 4'd0, 4'd0, 32'h0, 32'h0, 7'b1000000, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h0, 32'h0, 3'b000, 1'b0, 32'h0, 32'h0});
        // x1 has aged out of the history and comes from rs1_data.
        add_row('{32'h0, 32'h0, 4'd5, 4'd1, 4'd2, 32'h100, 32'h0, 7'b1000000, alu_or, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h10f, 32'h0, 3'b000, 1'b0, 32'h0, 32'hf});
        for (int k = 0; k < 4; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            add_row('{32'h0, 32'h0, 4'd0, 4'd13, 4'd14, ra, rb, 7'b0, rand_ops[k], br_never,
                      csr_none, 32'h0, 3'b000, 1'b1, alu_model(rand_ops[k], ra, rb), 32'h0,
                      3'b000, 1'b0, 32'h0, rb});
        end
        add_row('{32'h0, 32'h4, 4'd6, 4'd5, 4'd0, 32'h0, 32'h0, 7'b1101000, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h113, 32'h0, 3'b000, 1'b0, 32'h0, 32'h0});
        add_row('{32'h0, 32'h1, 4'd7, 4'd6, 4'd0, 32'h0, 32'h0, 7'b1001000, alu_add, br_never,
                  csr_none, 32'h0, 3'b100, 1'b1, 32'hcafe0001, 32'h0, 3'b000, 1'b0, 32'h0,
                  32'h0});
        add_row('{32'h100, 32'h40, 4'd0, 4'd7, 4'd8, 32'h0, 32'hcafe0001, 7'b0011000, alu_add,
                  br_eq, csr_none, 32'h0, 3'b000, 1'b1, 32'h104, 32'h0, 3'b000, 1'b1, 32'h140,
                  32'hcafe0001});
        add_row('{32'h104, 32'h0, 4'd9, 4'd0, 4'd0, 32'h0, 32'h0, 7'b1000000, alu_add, br_never,
                  csr_none, 32'h0, 3'b001, 1'b0, 32'h0, 32'h0, 3'b000, 1'b1, 32'h140, 32'h0});
        add_row('{32'h140, 32'h20, 4'd1, 4'd0, 4'd0, 32'h0, 32'h0, 7'b1011100, alu_add,
                  br_always, csr_none, 32'h0, 3'b001, 1'b1, 32'h144, 32'h0, 3'b000, 1'b1,
                  32'h160, 32'h0});
        add_row('{32'h160, 32'h4, 4'd0, 4'd0, 4'd0, 32'h0, 32'h0, 7'b0011100, alu_add,
                  br_always, csr_none, 32'h0, 3'b000, 1'b1, 32'h164, 32'h0, 3'b000, 1'b0, 32'h0,
                  32'h0});
        add_row('{32'h164, 32'h10, 4'd0, 4'd1, 4'd10, 32'h0, 32'h144, 7'b0011000, alu_add, br_ne,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h174, 32'h0, 3'b000, 1'b0, 32'h0, 32'h144});
        add_row('{32'h0, 32'h0, 4'd0, 4'd9, 4'd0, 32'h99, 32'h0, 7'b0, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h99, 32'h0, 3'b000, 1'b0, 32'h0, 32'h0});
        add_row('{32'h0, 32'h300, 4'd12, 4'd11, 4'd0, 32'h88, 32'h0, 7'b1000000, alu_add,
                  br_never, csr_rw, 32'h1800, 3'b000, 1'b1, 32'h1800, 32'h88, 3'b100, 1'b0,
                  32'h0, 32'h0});
        add_row('{32'h0, 32'h341, 4'd0, 4'd12, 4'd0, 32'h0, 32'h0, 7'b0, alu_add, br_never,
                  csr_rs, 32'h3, 3'b000, 1'b1, 32'h3, 32'h1803, 3'b001, 1'b0, 32'h0, 32'h0});
        add_row('{32'h180, 32'h0, 4'd0, 4'd0, 4'd0, 32'h0, 32'h0, 7'b0000010, alu_add, br_never,
                  csr_none, 32'h200, 3'b001, 1'b1, 32'h0, 32'h0, 3'b000, 1'b1, 32'h200, 32'h0});
        add_row('{32'h200, 32'h0, 4'd0, 4'd0, 4'd0, 32'h0, 32'h0, 7'b0000001, alu_add, br_never,
                  csr_none, 32'h1a4, 3'b001, 1'b1, 32'h0, 32'h0, 3'b000, 1'b1, 32'h1a4, 32'h0});
        add_row('{32'h0, 32'h0, 4'd0, 4'd0, 4'd0, 32'h11, 32'h22, 7'b0, alu_add, br_never,
                  csr_none, 32'h0, 3'b010, 1'b1, 32'h33, 32'h0, 3'b000, 1'b0, 32'h0, 32'h22});
        add_row('{32'h0, 32'h0, 4'd0, 4'd0, 4'd0, 32'h1, 32'h2, 7'b0, alu_add, br_never,
                  csr_none, 32'h0, 3'b000, 1'b1, 32'h3, 32'h0, 3'b000, 1'b0, 32'h0, 32'h2});

        fork
            begin
                #((n_rows + 4) * 10 * 40);
                $display("timeout: the DUT did not get through the table in time");
                $display("Some tests failed");
                $finish;
            end
        join_none

        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            run_row(tbl[i]);
        end

        $display("tb_exu: %0d rows, %0d errors", n_rows, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_bypass.sv
hdl/exu_redirect.sv
hdl/exu_stage.sv
verif/tb_exu_asserts.sv
verif/tb_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exu
FILELIST  ?= tb.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
